//--- bench/dds_modulation_tb.sv
`timescale 1ns/1ps

module dds_modulation_tb
   import dds_pkg::*;
();

   typedef struct packed {
      phase_t          inc;
      carrier_sel_e    csel;
      modulation_sel_e msel;
      logic [15:0]     cycles;
   } stim_row_t;

   localparam int NUM_ROWS      = 10;
   localparam int NUM_FIXED     = 7;
   localparam int CAPTURE_DEPTH = 1 << CAPTURE_AW;

   logic                    CLK_25MHZ;
   logic                    reset_from_key;
   phase_t                  phase_inc;
   carrier_sel_e            carrier_sel;
   modulation_sel_e         modulation_sel;
   logic                    key_event_ready;
   logic [EVENT_CODE_W-1:0] key_event_code;
   logic [CAPTURE_AW-1:0]   read_addr;
   sample_t                 carrier_sample;
   sample_t                 modulated_sample;
   logic                    sample_taken;
   plot_byte_t              read_carrier;
   plot_byte_t              read_modulated;
   logic [NUM_KEYS-1:0]     key_flags;

   //////////////////////////////////////////////////
   // reference model state
   //////////////////////////////////////////////////
   stim_row_t             stim_table [0:NUM_ROWS-1];
   sample_t               sine_ref [0:(1 << TABLE_AW)-1];
   phase_t                ref_phase;
   logic [LFSR_W-1:0]     ref_lfsr;
   sample_t               ref_sin;     // waves as the selector sees them
   sample_t               ref_cos;
   sample_t               ref_saw;
   sample_t               ref_squ;
   logic                  ref_symbol;
   sample_t               exp_carrier;
   sample_t               exp_modulated;
   logic [NUM_KEYS-1:0]   ref_flags;
   plot_byte_t            ref_cap_carrier [0:CAPTURE_DEPTH-1];
   plot_byte_t            ref_cap_modulated [0:CAPTURE_DEPTH-1];
   plot_byte_t            pend_carrier;   // written at the next edge
   plot_byte_t            pend_modulated;
   logic                  pend_write;
   logic                  readback_on;
   logic [CAPTURE_AW-1:0] ref_wr_ptr;
   int                    edge_count;
   int                    capture_count;

   initial begin
      CLK_25MHZ = 1'b0;
      forever #20 CLK_25MHZ = ~CLK_25MHZ;
   end

   dds_modulation_top dut (
      .CLK_25MHZ        (CLK_25MHZ),
      .reset_from_key   (reset_from_key),
      .phase_inc        (phase_inc),
      .carrier_sel      (carrier_sel),
      .modulation_sel   (modulation_sel),
      .key_event_ready  (key_event_ready),
      .key_event_code   (key_event_code),
      .read_addr        (read_addr),
      .carrier_sample   (carrier_sample),
      .modulated_sample (modulated_sample),
      .sample_taken     (sample_taken),
      .read_carrier     (read_carrier),
      .read_modulated   (read_modulated),
      .key_flags        (key_flags)
   );

   function automatic sample_t table_entry(input phase_t ph, input int ahead);
      int idx;
      idx = (int'(ph[PHASE_W-1 -: TABLE_AW]) + ahead) % (1 << TABLE_AW);
      return sine_ref[idx];
   endfunction

   function automatic plot_byte_t plot_of(input sample_t s);
      return s[SAMPLE_W-1 -: PLOT_W] ^ 8'h80;   // top byte with the sign flipped
   endfunction

   function automatic sample_t carrier_of(input carrier_sel_e sel);
      case (sel)
         CARRIER_SINE:   return ref_sin;
         CARRIER_COSINE: return ref_cos;
         CARRIER_SAW:    return ref_saw;
         default:        return ref_squ;
      endcase
   endfunction

   function automatic sample_t modulated_of(input modulation_sel_e sel);
      case (sel)
         MOD_ASK:  return ref_symbol ? ref_sin : '0;
         MOD_BPSK: return ref_symbol ? ref_sin : ~ref_sin;
         MOD_LFSR: return ref_symbol ? '0 : LFSR_HIGH;
         default:  return ref_sin;
      endcase
   endfunction

   task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                              input string what);
      if (got !== expected) begin
         $display("Fail at time %0t: %s is %0h, expected %0h", $time, what, got, expected);
         $display("SOME TESTS FAILED");
         $fatal(1, "stopped at the first mismatch");
      end
   endtask

   task automatic report_timeout(input string what);
      $display("timeout: gave up waiting for %s", what);
      $display("SOME TESTS FAILED");
      $fatal(1, "wait limit reached");
   endtask

   task automatic form_waves(input phase_t ph);
      ref_sin = table_entry(ph, 0);
      ref_cos = table_entry(ph, COS_OFFSET);
      ref_saw = ph[PHASE_W-1 -: SAMPLE_W];
      ref_squ = ph[PHASE_W-1] ? '0 : '1;   // high on the first half turn
   endtask

   task automatic apply_reset();
      reset_from_key = 1'b1;
      repeat (10) @(posedge CLK_25MHZ);
      #2;
      reset_from_key = 1'b0;
      check_value(key_flags, '0, "key_flags after reset");
      check_value(sample_taken, 0, "sample_taken after reset");
      ref_phase     = '0;
      ref_lfsr      = LFSR_SEED;
      ref_symbol    = LFSR_SEED[0];
      ref_flags     = '0;
      form_waves('0);   // waves settled on phase zero during reset
      edge_count    = 0;
      capture_count = 0;
      ref_wr_ptr    = '0;
      pend_write    = 1'b0;
      readback_on   = 1'b0;
   endtask

   //////////////////////////////////////////////////
   // one clock of model stepping and output checks
   //////////////////////////////////////////////////
   task automatic run_cycle();
      logic [CAPTURE_AW-1:0] addr_before;
      addr_before = read_addr;
      @(posedge CLK_25MHZ);
      exp_carrier   = carrier_of(carrier_sel);       // from waves before this edge
      exp_modulated = modulated_of(modulation_sel);
      form_waves(ref_phase);
      ref_phase = ref_phase + phase_inc;
      edge_count++;
      if (edge_count % SYMBOL_TICKS == 0) begin
         ref_lfsr = {ref_lfsr[LFSR_W-2:0], ref_lfsr[4] ^ ref_lfsr[2]};
      end
      ref_symbol = ref_lfsr[0];
      if (key_event_ready && (key_event_code[KEY_INDEX_W-1:0] < NUM_KEYS)) begin
         ref_flags[key_event_code[KEY_INDEX_W-1:0]] = ~key_event_code[EVENT_BREAK_BIT];
      end
      #2;
      check_value(carrier_sample, exp_carrier, "carrier_sample");
      check_value(modulated_sample, exp_modulated, "modulated_sample");
      check_value(key_flags, ref_flags, "key_flags");
      if (readback_on) begin
         check_value(read_carrier, ref_cap_carrier[addr_before], "read_carrier");
         check_value(read_modulated, ref_cap_modulated[addr_before], "read_modulated");
      end
      if (pend_write) begin   // memory took it at this edge
         ref_cap_carrier[ref_wr_ptr]   = pend_carrier;
         ref_cap_modulated[ref_wr_ptr] = pend_modulated;
         ref_wr_ptr++;
         pend_write = 1'b0;
      end
      check_value(sample_taken, (edge_count % SAMPLE_DIVIDE == 0), "sample_taken");
      if (sample_taken) begin
         pend_carrier   = plot_of(exp_carrier);
         pend_modulated = plot_of(exp_modulated);
         pend_write     = 1'b1;
         capture_count++;
      end
   endtask

   initial begin
      int                      unused_seed;
      int                      guard;
      logic [EVENT_CODE_W-1:0] code;
      unused_seed     = $urandom(35286);
      reset_from_key  = 1'b1;
      phase_inc       = '0;
      carrier_sel     = CARRIER_SINE;
      modulation_sel  = MOD_SINE;
      key_event_ready = 1'b0;
      key_event_code  = '0;
      read_addr       = '0;
      $readmemh(SINE_FILE, sine_ref);

      // inc, carrier, modulation, cycles
      stim_table[0] = '{32'h0400_0000, CARRIER_SAW,    MOD_SINE, 16'd100};
      stim_table[1] = '{32'h0123_4567, CARRIER_SQUARE, MOD_SINE, 16'd100};
      stim_table[2] = '{32'h0400_0000, CARRIER_SINE,   MOD_SINE, 16'd80};
      stim_table[3] = '{32'h0340_0000, CARRIER_COSINE, MOD_SINE, 16'd80};
      stim_table[4] = '{32'h0200_0000, CARRIER_SINE,   MOD_ASK,  16'd160};
      stim_table[5] = '{32'h0380_0000, CARRIER_COSINE, MOD_BPSK, 16'd160};
      stim_table[6] = '{32'h0100_0000, CARRIER_SAW,    MOD_LFSR, 16'd160};
      for (int r = NUM_FIXED; r < NUM_ROWS; r++) begin
         stim_table[r].inc    = $urandom;
         stim_table[r].csel   = carrier_sel_e'(r % 4);
         stim_table[r].msel   = modulation_sel_e'((r + 1) % 4);
         stim_table[r].cycles = 16'd120;
      end

      apply_reset();
      for (int r = 0; r < NUM_ROWS; r++) begin
         phase_inc      = stim_table[r].inc;
         carrier_sel    = stim_table[r].csel;
         modulation_sel = stim_table[r].msel;
         repeat (stim_table[r].cycles) run_cycle();
      end

      // memory must have wrapped before readback
      guard = 0;
      while (capture_count <= CAPTURE_DEPTH) begin
         if (guard == 1000) report_timeout("more than 64 scope captures");
         run_cycle();
         guard++;
      end
      readback_on = 1'b1;
      for (int a = 0; a < CAPTURE_DEPTH; a++) begin
         read_addr = CAPTURE_AW'(a);
         run_cycle();
      end
      readback_on = 1'b0;

      //////////////////////////////////////////////////
      // keyboard events in and out of range
      //////////////////////////////////////////////////
      for (int n = 0; n < 80; n++) begin
         code = EVENT_CODE_W'($urandom);
         key_event_ready = 1'b1;
         key_event_code  = code;
         run_cycle();
         key_event_ready = 1'b0;
         run_cycle();   // flags must hold
      end

      apply_reset();
      phase_inc      = stim_table[4].inc;
      carrier_sel    = CARRIER_SINE;
      modulation_sel = MOD_BPSK;
      repeat (60) run_cycle();

      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module dds_modulation_tb \
   -f sources.f -o dds_modulation_sim \
   && ./obj_dir/dds_modulation_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qsx "ALL TESTS PASSED" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

//--- sine_table.hex
// one sine period, 64 lines, one 12-bit offset binary sample per line
800
8C9
98F
A52
B0F
BC5
C71
D13
DA7
E2E
EA6
F0D
F63
FA7
FD8
FF5
FFF
FF5
FD8
FA7
F63
F0D
EA6
E2E
DA7
D13
C71
BC5
B0F
A52
98F
8C9
800
737
671
5AE
4F1
43B
38F
2ED
259
1D2
15A
0F3
09D
059
028
00B
001
00B
028
059
09D
0F3
15A
1D2
259
2ED
38F
43B
4F1
5AE
671
737

//--- sources.f
src/dds_pkg.sv
src/waveform_if.sv
src/symbol_lfsr.sv
src/dds_waveform_gen.sv
src/modulation_select.sv
src/scope_capture_buffer.sv
src/key_state_tracker.sv
src/dds_modulation_top.sv
bench/dds_modulation_tb.sv

//--- src/dds_modulation_top.sv
`timescale 1ns/1ps

module dds_modulation_top
   import dds_pkg::*;
(
   input  logic                    CLK_25MHZ,
   input  logic                    reset_from_key,

   // generator and selector controls
   input  phase_t                  phase_inc,
   input  carrier_sel_e            carrier_sel,
   input  modulation_sel_e         modulation_sel,

   // keyboard events
   input  logic                    key_event_ready,
   input  logic [EVENT_CODE_W-1:0] key_event_code,

   // scope readback
   input  logic [CAPTURE_AW-1:0]   read_addr,

   output sample_t                 carrier_sample,
   output sample_t                 modulated_sample,
   output logic                    sample_taken,
   output plot_byte_t              read_carrier,
   output plot_byte_t              read_modulated,
   output logic [NUM_KEYS-1:0]     key_flags
);

   waveform_if waves ();

   //////////////////////////////////////////////////
   // signal chain
   //////////////////////////////////////////////////
   dds_waveform_gen u_waveform_gen (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .phase_inc      (phase_inc),
      .waves          (waves.generator)
   );

   modulation_select u_modulation_select (
      .CLK_25MHZ        (CLK_25MHZ),
      .reset_from_key   (reset_from_key),
      .waves            (waves.selector),
      .carrier_sel      (carrier_sel),
      .modulation_sel   (modulation_sel),
      .carrier_sample   (carrier_sample),
      .modulated_sample (modulated_sample)
   );

   scope_capture_buffer u_scope_capture (
      .CLK_25MHZ        (CLK_25MHZ),
      .reset_from_key   (reset_from_key),
      .carrier_sample   (carrier_sample),     // same samples the outputs show
      .modulated_sample (modulated_sample),
      .read_addr        (read_addr),
      .sample_taken     (sample_taken),
      .read_carrier     (read_carrier),
      .read_modulated   (read_modulated)
   );

   //////////////////////////////////////////////////
   // keyboard
   //////////////////////////////////////////////////
   key_state_tracker u_key_tracker (
      .CLK_25MHZ       (CLK_25MHZ),
      .reset_from_key  (reset_from_key),
      .key_event_ready (key_event_ready),
      .key_event_code  (key_event_code),
      .key_flags       (key_flags)
   );

endmodule

//--- src/dds_pkg.sv
package dds_pkg;

   //////////////////////////////////////////////////
   // datapath widths
   //////////////////////////////////////////////////
   localparam int SAMPLE_W = 12;   // offset binary samples
   localparam int PHASE_W  = 32;
   localparam int PLOT_W   = 8;    // one scope row value

   typedef logic [SAMPLE_W-1:0] sample_t;
   typedef logic [PLOT_W-1:0]   plot_byte_t;
   typedef logic [PHASE_W-1:0]  phase_t;

   // sine rom, addressed by the top phase bits
   localparam int    TABLE_AW   = 6;
   localparam int    COS_OFFSET = 16;               // quarter period
   localparam string SINE_FILE  = "sine_table.hex";

   //////////////////////////////////////////////////
   // symbol source and capture timing
   //////////////////////////////////////////////////
   localparam int             LFSR_W       = 5;
   localparam logic [LFSR_W-1:0] LFSR_SEED = 5'b00001;
   localparam int             SYMBOL_TICKS = 16;    // clocks per lfsr step
   localparam int             TICK_W       = $clog2(SYMBOL_TICKS);

   localparam int SAMPLE_DIVIDE = 8;                // clocks per capture
   localparam int SAMPLE_CNT_W  = $clog2(SAMPLE_DIVIDE);
   localparam int CAPTURE_AW    = 6;                // 64 entries

   // carrier and modulation choices
   typedef enum logic [1:0] {
      CARRIER_SINE   = 2'd0,
      CARRIER_COSINE = 2'd1,
      CARRIER_SAW    = 2'd2,
      CARRIER_SQUARE = 2'd3
   } carrier_sel_e;

   typedef enum logic [1:0] {
      MOD_ASK  = 2'd0,
      MOD_SINE = 2'd1,
      MOD_BPSK = 2'd2,
      MOD_LFSR = 2'd3
   } modulation_sel_e;

   localparam sample_t LFSR_HIGH = 12'h800;         // level for a 0 symbol

   //////////////////////////////////////////////////
   // keyboard events
   //////////////////////////////////////////////////
   localparam int EVENT_CODE_W    = 8;
   localparam int EVENT_BREAK_BIT = 7;   // set on key release
   localparam int KEY_INDEX_W     = 5;   // low bits of the code
   localparam int NUM_KEYS        = 17;

   // flag positions, msb first as on the board
   localparam int KEY_1 = 16, KEY_2 = 15, KEY_3 = 14, KEY_4 = 13;
   localparam int KEY_5 = 12, KEY_6 = 11, KEY_7 = 10, KEY_8 = 9;
   localparam int KEY_F1 = 8, KEY_F2 = 7, KEY_N = 6, KEY_M = 5;
   localparam int KEY_SPACE = 4, KEY_LEFT = 3, KEY_RIGHT = 2;
   localparam int KEY_UP = 1, KEY_DOWN = 0;

endpackage

//--- src/dds_waveform_gen.sv
`timescale 1ns/1ps

module dds_waveform_gen
   import dds_pkg::*;
(
   input  logic                CLK_25MHZ,
   input  logic                reset_from_key,
   input  phase_t              phase_inc,
   waveform_if.generator       waves
);

   phase_t                phase;
   logic [TABLE_AW-1:0]   sin_addr;
   logic [TABLE_AW-1:0]   cos_addr;

   // one period of sine, offset binary
   sample_t sine_rom [0:(1 << TABLE_AW)-1];

   initial begin
      $readmemh(SINE_FILE, sine_rom);
   end

   //////////////////////////////////////////////////
   // phase accumulator
   //////////////////////////////////////////////////
   always_ff @(posedge CLK_25MHZ) begin
      if (reset_from_key) begin
         phase <= '0;
      end else begin
         phase <= phase + phase_inc;   // free running, wraps at 2^32
      end
   end

   assign sin_addr = phase[PHASE_W-1 -: TABLE_AW];
   assign cos_addr = sin_addr + TABLE_AW'(COS_OFFSET);   // quarter turn ahead, wraps

   //////////////////////////////////////////////////
   // carriers
   //////////////////////////////////////////////////
   // registered from the current phase, so they trail it by one clock
   always_ff @(posedge CLK_25MHZ) begin
      waves.sin_wave <= sine_rom[sin_addr];
      waves.cos_wave <= sine_rom[cos_addr];
      waves.saw_wave <= phase[PHASE_W-1 -: SAMPLE_W];       // ramp is the phase itself
      waves.squ_wave <= {SAMPLE_W{~phase[PHASE_W-1]}};      // high for first half turn
   end

   // slow symbol for the modulators
   symbol_lfsr u_symbol_lfsr (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .symbol         (waves.symbol)
   );

endmodule

//--- src/key_state_tracker.sv
`timescale 1ns/1ps

module key_state_tracker
   import dds_pkg::*;
(
   input  logic                    CLK_25MHZ,
   input  logic                    reset_from_key,
   input  logic                    key_event_ready,
   input  logic [EVENT_CODE_W-1:0] key_event_code,
   output logic [NUM_KEYS-1:0]     key_flags
);

   logic                   is_break;
   logic [KEY_INDEX_W-1:0] key_index;
   logic                   index_valid;

   //////////////////////////////////////////////////
   // event decode
   //////////////////////////////////////////////////
   assign is_break    = key_event_code[EVENT_BREAK_BIT];   // release
   assign key_index   = key_event_code[KEY_INDEX_W-1:0];
   assign index_valid = (key_index < KEY_INDEX_W'(NUM_KEYS));   // keys we do not track are dropped

   //////////////////////////////////////////////////
   // held flags
   //////////////////////////////////////////////////
   // a make sets the flag, the matching break clears it
   always_ff @(posedge CLK_25MHZ) begin
      if (reset_from_key) begin
         key_flags <= '0;
      end else if (key_event_ready && index_valid) begin
         key_flags[key_index] <= ~is_break;
      end
   end

endmodule

//--- src/modulation_select.sv
`timescale 1ns/1ps

module modulation_select
   import dds_pkg::*;
(
   input  logic            CLK_25MHZ,
   input  logic            reset_from_key,
   waveform_if.selector    waves,
   input  carrier_sel_e    carrier_sel,
   input  modulation_sel_e modulation_sel,
   output sample_t         carrier_sample,
   output sample_t         modulated_sample
);

   sample_t ask_wave;
   sample_t bpsk_wave;
   sample_t lfsr_wave;
   sample_t carrier_mux;
   sample_t modulated_mux;

   // keyed versions of the sine carrier
   assign ask_wave  = waves.symbol ? waves.sin_wave : '0;
   assign bpsk_wave = waves.symbol ? waves.sin_wave : ~waves.sin_wave;   // phase flip
   assign lfsr_wave = waves.symbol ? '0 : LFSR_HIGH;

   always_comb begin
      carrier_mux = waves.sin_wave;
      case (carrier_sel)
         CARRIER_COSINE: carrier_mux = waves.cos_wave;
         CARRIER_SAW:    carrier_mux = waves.saw_wave;
         CARRIER_SQUARE: carrier_mux = waves.squ_wave;
         default:        carrier_mux = waves.sin_wave;
      endcase
   end

   always_comb begin
      modulated_mux = waves.sin_wave;   // plain sine
      case (modulation_sel)
         MOD_ASK:  modulated_mux = ask_wave;
         MOD_BPSK: modulated_mux = bpsk_wave;
         MOD_LFSR: modulated_mux = lfsr_wave;
         default:  modulated_mux = waves.sin_wave;
      endcase
   end

   // one clock behind the waves
   always_ff @(posedge CLK_25MHZ) begin
      carrier_sample   <= carrier_mux;
      modulated_sample <= reset_from_key ? carrier_mux : modulated_mux;
   end

endmodule

//--- src/scope_capture_buffer.sv
`timescale 1ns/1ps

module scope_capture_buffer
   import dds_pkg::*;
(
   input  logic                  CLK_25MHZ,
   input  logic                  reset_from_key,
   input  sample_t               carrier_sample,
   input  sample_t               modulated_sample,
   input  logic [CAPTURE_AW-1:0] read_addr,
   output logic                  sample_taken,
   output plot_byte_t            read_carrier,
   output plot_byte_t            read_modulated
);

   logic [SAMPLE_CNT_W-1:0] div_cnt;
   logic [CAPTURE_AW-1:0]   wr_ptr;

   plot_byte_t carrier_mem   [0:(1 << CAPTURE_AW)-1];
   plot_byte_t modulated_mem [0:(1 << CAPTURE_AW)-1];

   // flip msb to signed, keep the next 7 bits
   function automatic plot_byte_t to_plot(input sample_t s);
      return {~s[SAMPLE_W-1], s[SAMPLE_W-2 -: PLOT_W-1]};
   endfunction

   //////////////////////////////////////////////////
   // sample strobe and write pointer
   //////////////////////////////////////////////////
   always_ff @(posedge CLK_25MHZ) begin
      if (reset_from_key) begin
         div_cnt      <= '0;
         sample_taken <= 1'b0;
         wr_ptr       <= '0;
      end else begin
         div_cnt      <= div_cnt + 1'b1;
         sample_taken <= (div_cnt == SAMPLE_CNT_W'(SAMPLE_DIVIDE - 1));   // one clock wide
         if (sample_taken) begin
            wr_ptr <= wr_ptr + 1'b1;   // circular, oldest entry overwritten
         end
      end
   end

   //////////////////////////////////////////////////
   // capture memory
   //////////////////////////////////////////////////
   always_ff @(posedge CLK_25MHZ) begin
      if (sample_taken) begin
         carrier_mem[wr_ptr]   <= to_plot(carrier_sample);
         modulated_mem[wr_ptr] <= to_plot(modulated_sample);
      end
      read_carrier   <= carrier_mem[read_addr];     // registered read
      read_modulated <= modulated_mem[read_addr];
   end

endmodule

//--- src/symbol_lfsr.sv
`timescale 1ns/1ps

module symbol_lfsr
   import dds_pkg::*;
(
   input  logic CLK_25MHZ,
   input  logic reset_from_key,
   output logic symbol
);

   logic [TICK_W-1:0] tick_cnt;
   logic [LFSR_W-1:0] lfsr;
   logic              tick;

   assign tick = (tick_cnt == TICK_W'(SYMBOL_TICKS - 1));   // last clock of a symbol

   always_ff @(posedge CLK_25MHZ) begin
      if (reset_from_key) begin
         tick_cnt <= '0;
         lfsr     <= LFSR_SEED;
      end else begin
         tick_cnt <= tick_cnt + 1'b1;   // wraps on its own
         if (tick) begin
            // shift up, feedback from taps 4 and 2
            lfsr <= {lfsr[LFSR_W-2:0], lfsr[4] ^ lfsr[2]};
         end
      end
   end

   assign symbol = lfsr[0];

endmodule

//--- src/waveform_if.sv
`timescale 1ns/1ps

// carriers and symbol, all plain levels updated every clock
interface waveform_if
   import dds_pkg::*;
();

   sample_t sin_wave;
   sample_t cos_wave;
   sample_t saw_wave;
   sample_t squ_wave;
   logic    symbol;     // lfsr bit 0

   modport generator (
      output sin_wave, cos_wave, saw_wave, squ_wave, symbol
   );

   modport selector (
      input sin_wave, cos_wave, saw_wave, squ_wave, symbol
   );

endinterface
